//--- acqDataFifo.sv
`timescale 1ns/1ps
`default_nettype none

module acqDataFifo import sweepPkg::*; (
    input  logic                 Clk,
    input  logic                 reset_n,
    // Synchronous flush of the whole buffer
    input  logic                 clear,
    input  logic                 writeEn,
    input  logic [DataWidth-1:0] writeData,
    input  logic                 readEn,
    // Valid one cycle after an accepted read
    output logic [DataWidth-1:0] readData,
    output logic                 full,
    output logic                 empty
);

    // Storage array
    logic [DataWidth-1:0] mem [FifoDepth];

    // Pointers wrap on their own since depth is a power of two
    logic [FifoAddrWidth-1:0] writePtr;
    logic [FifoAddrWidth-1:0] readPtr;
    // One bit wider than the pointers to tell full from empty
    logic [FifoAddrWidth:0]   fillCount;

    logic doWrite;
    logic doRead;

    assign full  = (fillCount == (FifoAddrWidth+1)'(FifoDepth));
    assign empty = (fillCount == '0);

    // Overflow and underflow are silently dropped
    assign doWrite = writeEn && !full;
    assign doRead  = readEn && !empty;

    ////////////////////////////////////////////////////////////
    // Pointer and count bookkeeping
    ////////////////////////////////////////////////////////////
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            writePtr  <= '0;
            readPtr   <= '0;
            fillCount <= '0;
        end else if (clear) begin
            // Clear wins over any access in the same cycle
            writePtr  <= '0;
            readPtr   <= '0;
            fillCount <= '0;
        end else begin
            if (doWrite) begin
                writePtr <= writePtr + 1'b1;
            end
            if (doRead) begin
                readPtr <= readPtr + 1'b1;
            end
            // Net change of occupancy
            if (doWrite && !doRead) begin
                fillCount <= fillCount + 1'b1;
            end else if (doRead && !doWrite) begin
                fillCount <= fillCount - 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Data array with registered read port
    ////////////////////////////////////////////////////////////
    always_ff @(posedge Clk) begin
        if (doWrite && !clear) begin
            mem[writePtr] <= writeData;
        end
        if (doRead) begin
            readData <= mem[readPtr];
        end
    end

endmodule

`default_nettype wire

//--- files.f
sweepPkg.sv
sweepStepIf.sv
acqDataFifo.sv
sweepController.sv
stepFramer.sv
sweepAcqTop.sv
tbSweepAcqTop.sv

//--- runSim.sh
#!/bin/sh
# Build the sweep acquisition testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --timescale 1ns/1ps -f files.f --top-module tbSweepAcqTop \
    -o tbSweepAcqTop > build.log 2>&1 \
    && ./obj_dir/tbSweepAcqTop > sim.log 2>&1 \
    || { cat build.log; echo "Build or simulation run error"; exit 1; }
cat sim.log
grep -q "test failed" sim.log && exit 1
grep -q "test passed" sim.log || exit 1
exit 0

//--- stepFramer.sv
`timescale 1ns/1ps
`default_nettype none

module stepFramer import sweepPkg::*; (
    input  logic                 Clk,
    input  logic                 reset_n,
    // Step buffer read side
    input  logic [DataWidth-1:0] fifoData,
    input  logic                 fifoEmpty,
    output logic                 fifoReadEn,
    // USB stream
    input  logic                 UsbDataFifoFull,
    output logic [DataWidth-1:0] SweepACQData,
    output logic                 SweepACQData_en,
    sweepStepIf.framer           step
);

    logic                  busy;
    // Words still to be read for this step
    logic [CountWidth-1:0] remaining;
    // Read issued last cycle, data on fifoData now
    logic                  readPending;

    // Output stage
    logic                  outValid;
    logic [DataWidth-1:0]  outData;
    // Skid slot for a read that lands while USB is full
    logic                  holdValid;
    logic [DataWidth-1:0]  holdData;

    logic       outFire;
    logic       outFree;
    logic [1:0] slotsUsed;
    logic       stepDone;

    // Word leaves only while USB has room
    assign outFire = outValid && !UsbDataFifoFull;
    assign outFree = !outValid || outFire;

    // Output slot, skid slot and in-flight read share two places
    assign slotsUsed = {1'b0, outValid && !outFire} + {1'b0, holdValid} + {1'b0, readPending};

    assign fifoReadEn = busy && (remaining != '0) && !fifoEmpty && (slotsUsed < 2'd2);

    // Count exhausted or buffer ran dry, nothing left in the pipe
    assign stepDone = busy && !outValid && !holdValid && !readPending
                   && ((remaining == '0) || fifoEmpty);

    assign SweepACQData    = outData;
    assign SweepACQData_en = outFire;

    ////////////////////////////////////////////////////////////
    // Step tracking and drain report
    ////////////////////////////////////////////////////////////
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            busy             <= 1'b0;
            remaining        <= '0;
            readPending      <= 1'b0;
            step.stepDrained <= 1'b0;
        end else begin
            readPending      <= fifoReadEn;
            step.stepDrained <= stepDone;
            if (step.stepStart) begin
                busy      <= 1'b1;
                remaining <= step.stepWords;
            end else begin
                if (fifoReadEn) begin
                    remaining <= remaining - 1'b1;
                end
                if (stepDone) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Output and skid registers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            outValid  <= 1'b0;
            outData   <= '0;
            holdValid <= 1'b0;
            holdData  <= '0;
        end else if (step.stepStart) begin
            // Pipe is empty here, header goes out first
            outValid <= 1'b1;
            outData  <= {HeaderMarker, step.stepDac};
        end else if (outFree) begin
            if (holdValid) begin
                // Skid word first, then park any new arrival
                outValid  <= 1'b1;
                outData   <= holdData;
                holdValid <= readPending;
                holdData  <= fifoData;
            end else if (readPending) begin
                outValid <= 1'b1;
                outData  <= fifoData;
            end else begin
                outValid <= 1'b0;
            end
        end else if (readPending) begin
            // Output blocked by USB full
            holdValid <= 1'b1;
            holdData  <= fifoData;
        end
    end

endmodule

`default_nettype wire

//--- sweepAcqTop.sv
`timescale 1ns/1ps
`default_nettype none

module sweepAcqTop import sweepPkg::*; (
    input  logic                  Clk,
    input  logic                  reset_n,
    // Acquisition control
    input  logic                  SweepStart,
    output logic                  SingleACQStart,
    output logic                  ForceMicrorocAcqReset,
    output logic                  ACQDone,
    input  logic                  DataTransmitDone,
    // Sweep parameters
    input  logic [DacWidth-1:0]   StartDAC0,
    input  logic [DacWidth-1:0]   EndDAC0,
    input  logic [CountWidth-1:0] MaxPackageNumber,
    // ASIC readout words
    input  logic [DataWidth-1:0]  ParallelData,
    input  logic                  ParallelData_en,
    // Slow control
    output logic [DacWidth-1:0]   OutDAC0,
    output logic                  LoadSCParameter,
    input  logic                  MicrorocConfigDone,
    // USB stream
    output logic [DataWidth-1:0]  SweepACQData,
    output logic                  SweepACQData_en,
    input  logic                  UsbDataFifoFull
);

    // Step hand-off between controller and framer
    sweepStepIf stepLink ();

    logic                 acqWindow;
    logic                 fifoClear;
    logic                 fifoWriteEn;
    logic                 fifoReadEn;
    logic [DataWidth-1:0] fifoData;
    logic                 fifoEmpty;

    ////////////////////////////////////////////////////////////
    // Sequencing of DAC steps and ASIC acquisitions
    ////////////////////////////////////////////////////////////
    sweepController sweepCtrl (
        .Clk                   (Clk),
        .reset_n               (reset_n),
        .SweepStart            (SweepStart),
        .MicrorocConfigDone    (MicrorocConfigDone),
        .DataTransmitDone      (DataTransmitDone),
        .StartDAC0             (StartDAC0),
        .EndDAC0               (EndDAC0),
        .MaxPackageNumber      (MaxPackageNumber),
        .ParallelData_en       (ParallelData_en),
        .OutDAC0               (OutDAC0),
        .LoadSCParameter       (LoadSCParameter),
        .SingleACQStart        (SingleACQStart),
        .ForceMicrorocAcqReset (ForceMicrorocAcqReset),
        .ACQDone               (ACQDone),
        .acqWindow             (acqWindow),
        .fifoClear             (fifoClear),
        .step                  (stepLink)
    );

    // Only words inside a step window are buffered
    assign fifoWriteEn = ParallelData_en && acqWindow;

    // Words past a full buffer are dropped inside the FIFO
    acqDataFifo dataFifo (
        .Clk       (Clk),
        .reset_n   (reset_n),
        .clear     (fifoClear),
        .writeEn   (fifoWriteEn),
        .writeData (ParallelData),
        .readEn    (fifoReadEn),
        .readData  (fifoData),
        .full      (),
        .empty     (fifoEmpty)
    );

    ////////////////////////////////////////////////////////////
    // Header plus data toward the USB FIFO
    ////////////////////////////////////////////////////////////
    stepFramer framer (
        .Clk             (Clk),
        .reset_n         (reset_n),
        .fifoData        (fifoData),
        .fifoEmpty       (fifoEmpty),
        .fifoReadEn      (fifoReadEn),
        .UsbDataFifoFull (UsbDataFifoFull),
        .SweepACQData    (SweepACQData),
        .SweepACQData_en (SweepACQData_en),
        .step            (stepLink)
    );

endmodule

`default_nettype wire

//--- sweepController.sv
`timescale 1ns/1ps
`default_nettype none

module sweepController import sweepPkg::*; (
    input  logic                  Clk,
    input  logic                  reset_n,
    // Sweep request, level from the host side
    input  logic                  SweepStart,
    input  logic                  MicrorocConfigDone,
    input  logic                  DataTransmitDone,
    // Sweep range and words per step
    input  logic [DacWidth-1:0]   StartDAC0,
    input  logic [DacWidth-1:0]   EndDAC0,
    input  logic [CountWidth-1:0] MaxPackageNumber,
    input  logic                  ParallelData_en,
    // Slow control side
    output logic [DacWidth-1:0]   OutDAC0,
    output logic                  LoadSCParameter,
    // ASIC acquisition strobes
    output logic                  SingleACQStart,
    output logic                  ForceMicrorocAcqReset,
    output logic                  ACQDone,
    // Buffer control
    output logic                  acqWindow,
    output logic                  fifoClear,
    sweepStepIf.controller        step
);

    sweepState_t state;

    // Two-flop synchronizer plus one stage for the edge
    logic startSync1;
    logic startSync2;
    logic startSync3;
    logic startEdge;

    // DAC value of the step in progress
    logic [DacWidth-1:0]   dacValue;
    // Words accepted in the current window
    logic [CountWidth-1:0] wordCount;
    logic [CountWidth-1:0] countNext;
    logic                  wordAccept;
    logic                  collectEnd;
    logic                  lastStep;

    ////////////////////////////////////////////////////////////
    // SweepStart synchronizer and rising edge
    ////////////////////////////////////////////////////////////
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            startSync1 <= 1'b0;
            startSync2 <= 1'b0;
            startSync3 <= 1'b0;
        end else begin
            startSync1 <= SweepStart;
            startSync2 <= startSync1;
            startSync3 <= startSync2;
        end
    end

    assign startEdge = startSync2 && !startSync3;

    ////////////////////////////////////////////////////////////
    // Word counting inside the acquisition window
    ////////////////////////////////////////////////////////////

    // Window closes by itself once the limit is reached
    assign acqWindow  = (state == Collect) && (wordCount < MaxPackageNumber);
    assign wordAccept = acqWindow && ParallelData_en;
    assign countNext  = wordCount + CountWidth'(wordAccept);
    // Limit reached or readout finished early
    assign collectEnd = DataTransmitDone || (countNext >= MaxPackageNumber);

    // Also covers StartDAC0 above EndDAC0
    assign lastStep = (dacValue >= EndDAC0);

    ////////////////////////////////////////////////////////////
    // Step sequencer
    ////////////////////////////////////////////////////////////
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            state     <= Idle;
            dacValue  <= '0;
            wordCount <= '0;
        end else begin
            unique case (state)
                Idle: begin
                    // Edges seen in any other state are dropped
                    if (startEdge) begin
                        dacValue <= StartDAC0;
                        state    <= LoadDac;
                    end
                end
                LoadDac: begin
                    state <= WaitConfig;
                end
                WaitConfig: begin
                    if (MicrorocConfigDone) begin
                        state <= StartAcq;
                    end
                end
                StartAcq: begin
                    wordCount <= '0;
                    state     <= Collect;
                end
                Collect: begin
                    wordCount <= countNext;
                    if (collectEnd) begin
                        state <= ResetAsic;
                    end
                end
                ResetAsic: begin
                    state <= Drain;
                end
                Drain: begin
                    // Framer owns the buffer until it reports back
                    if (step.stepDrained) begin
                        state <= NextStep;
                    end
                end
                NextStep: begin
                    if (lastStep) begin
                        state <= Idle;
                    end else begin
                        dacValue <= dacValue + 1'b1;
                        state    <= LoadDac;
                    end
                end
                default: begin
                    state <= Idle;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Strobes decoded from the state
    ////////////////////////////////////////////////////////////
    assign OutDAC0               = dacValue;
    assign LoadSCParameter       = (state == LoadDac);
    assign SingleACQStart        = (state == StartAcq);
    assign ForceMicrorocAcqReset = (state == ResetAsic);
    // Single pulse after the final step has drained
    assign ACQDone               = (state == NextStep) && lastStep;

    // Flush leftovers after a drain and before each new window
    assign fifoClear = step.stepDrained || (state == StartAcq);

    // Step hand-off, stable for the whole Drain phase
    assign step.stepStart = (state == ResetAsic);
    assign step.stepDac   = dacValue;
    assign step.stepWords = wordCount;

endmodule

`default_nettype wire

//--- sweepPkg.sv
`default_nettype none

package sweepPkg;

    ////////////////////////////////////////////////////////////
    // Fixed widths of the Microroc readout interface
    ////////////////////////////////////////////////////////////

    // Threshold DAC0 of the ASIC
    localparam int DacWidth = 10;
    // Parallel readout word and USB output word
    localparam int DataWidth = 16;
    // MaxPackageNumber and per-step word counters
    localparam int CountWidth = 16;

    // Step buffer geometry
    localparam int FifoDepth = 128;
    localparam int FifoAddrWidth = 7;

    // Upper six bits of every step header
    localparam logic [DataWidth-DacWidth-1:0] HeaderMarker = 6'b101010;

    ////////////////////////////////////////////////////////////
    // Sweep controller states
    ////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        Idle,
        LoadDac,
        WaitConfig,
        StartAcq,
        Collect,
        ResetAsic,
        Drain,
        NextStep
    } sweepState_t;

endpackage

`default_nettype wire

//--- sweepStepIf.sv
`timescale 1ns/1ps
`default_nettype none

// Hand-off of one finished step from controller to framer
interface sweepStepIf import sweepPkg::*; ();

    // Strobe that opens a step for the framer
    logic                  stepStart;
    // DAC value of the step, used in the header word
    logic [DacWidth-1:0]   stepDac;
    // Words buffered during the step
    logic [CountWidth-1:0] stepWords;
    // Strobe back once the last word left the framer
    logic                  stepDrained;

    modport controller (
        output stepStart,
        output stepDac,
        output stepWords,
        input  stepDrained
    );

    modport framer (
        input  stepStart,
        input  stepDac,
        input  stepWords,
        output stepDrained
    );

endinterface

`default_nettype wire

//--- tbSweepAcqTop.sv
`timescale 1ns/1ps
`default_nettype none

module tbSweepAcqTop;

    // One sweep per row
    typedef struct {
        int startDac;
        int endDac;
        int maxWords;
        int offered;
        int earlyStop;
        int backPressure;
    } sweepRow_t;

    localparam int RowCount = 7;
    // Upper header bits, DAC value sits below
    localparam logic [5:0] HdrTag = 6'b101010;

    logic Clk = 1'b0;
    logic reset_n;
    logic SweepStart;
    logic SingleACQStart;
    logic ForceMicrorocAcqReset;
    logic ACQDone;
    logic DataTransmitDone;
    logic [9:0] StartDAC0;
    logic [9:0] EndDAC0;
    logic [15:0] MaxPackageNumber;
    logic [15:0] ParallelData;
    logic ParallelData_en;
    logic [9:0] OutDAC0;
    logic LoadSCParameter;
    logic MicrorocConfigDone;
    logic [15:0] SweepACQData;
    logic SweepACQData_en;
    logic UsbDataFifoFull;

    sweepRow_t sweepRows [RowCount];
    // Expected output stream, DAC loads and words the ASIC model offers
    logic [15:0] expQ [$];
    int expDacQ [$];
    logic [15:0] offeredQ [$];

    int errCount = 0;
    int acqDoneTotal = 0;
    int cycleCount = 0;
    int cycleLimit = 0;
    int offeredPerStep = 0;
    int earlyStopOn = 0;
    int pressureOn = 0;
    int failedSweeps = 0;

    sweepAcqTop dut_i (
        .Clk                   (Clk),
        .reset_n               (reset_n),
        .SweepStart            (SweepStart),
        .SingleACQStart        (SingleACQStart),
        .ForceMicrorocAcqReset (ForceMicrorocAcqReset),
        .ACQDone               (ACQDone),
        .DataTransmitDone      (DataTransmitDone),
        .StartDAC0             (StartDAC0),
        .EndDAC0               (EndDAC0),
        .MaxPackageNumber      (MaxPackageNumber),
        .ParallelData          (ParallelData),
        .ParallelData_en       (ParallelData_en),
        .OutDAC0               (OutDAC0),
        .LoadSCParameter       (LoadSCParameter),
        .MicrorocConfigDone    (MicrorocConfigDone),
        .SweepACQData          (SweepACQData),
        .SweepACQData_en       (SweepACQData_en),
        .UsbDataFifoFull       (UsbDataFifoFull)
    );

    always #20 Clk = ~Clk;

    // Run limit, ends a hung sweep
    always @(posedge Clk) begin
        cycleCount = cycleCount + 1;
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            $display("Timeout: sweeps did not finish within %0d cycles", cycleLimit);
            $display("test failed");
            $finish;
        end
    end

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s: got %h expected %h (cycle %0d)", name, got, exp, cycleCount);
            errCount++;
        end
    endtask

    // Cycles needed by the whole table with a wide margin
    function automatic int cycleBudget();
        int total;
        int steps;
        total = 200;
        for (int r = 0; r < RowCount; r++) begin
            steps = (sweepRows[r].startDac > sweepRows[r].endDac) ? 1
                  : sweepRows[r].endDac - sweepRows[r].startDac + 1;
            total += 80 + steps * (40 + 6 * sweepRows[r].offered);
        end
        return total;
    endfunction

    ////////////////////////////////////////////////////////////
    // Slow control model, config done a few cycles after load
    ////////////////////////////////////////////////////////////
    initial begin
        int cfgDelay;
        MicrorocConfigDone = 1'b0;
        forever begin
            @(negedge Clk);
            if (LoadSCParameter) begin
                cfgDelay = 1 + int'($urandom % 3);
                repeat (cfgDelay) @(posedge Clk);
                #2 MicrorocConfigDone = 1'b1;
                @(posedge Clk);
                #2 MicrorocConfigDone = 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // ASIC readout model
    ////////////////////////////////////////////////////////////
    initial begin
        int sent;
        int halted;
        ParallelData     = 16'h0000;
        ParallelData_en  = 1'b0;
        DataTransmitDone = 1'b0;
        forever begin
            @(negedge Clk);
            if (SingleACQStart) begin
                sent   = 0;
                halted = 0;
                while (sent < offeredPerStep && halted == 0) begin
                    @(posedge Clk);
                    #2;
                    // Random gaps between words
                    if ($urandom % 3 == 0) begin
                        ParallelData_en = 1'b0;
                    end else begin
                        ParallelData    = offeredQ.pop_front();
                        ParallelData_en = 1'b1;
                        sent++;
                    end
                    @(negedge Clk);
                    // ASIC reset ends the readout
                    if (ForceMicrorocAcqReset) begin
                        halted = 1;
                    end
                end
                // Words never sent are dropped from the model
                while (sent < offeredPerStep) begin
                    void'(offeredQ.pop_front());
                    sent++;
                end
                @(posedge Clk);
                #2 ParallelData_en = 1'b0;
                DataTransmitDone = (earlyStopOn != 0);
                @(posedge Clk);
                #2 DataTransmitDone = 1'b0;
            end
        end
    end

    // USB FIFO model, full for random stretches
    initial begin
        int stretch;
        UsbDataFifoFull = 1'b0;
        stretch = 0;
        forever begin
            @(posedge Clk);
            #2;
            if (pressureOn == 0) begin
                UsbDataFifoFull = 1'b0;
                stretch = 0;
            end else if (stretch == 0) begin
                UsbDataFifoFull = ($urandom % 2) == 1;
                stretch = 1 + int'($urandom % 4);
            end else begin
                stretch--;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Output monitor, sampled mid-cycle
    ////////////////////////////////////////////////////////////
    initial begin
        logic [15:0] expWord;
        int expDac;
        forever begin
            @(negedge Clk);
            if (reset_n) begin
                if (SweepACQData_en) begin
                    if (UsbDataFifoFull) begin
                        $display("SweepACQData_en high while UsbDataFifoFull is set, cycle %0d",
                                 cycleCount);
                        errCount++;
                    end
                    if (expQ.size() == 0) begin
                        $display("Unexpected output word %h at cycle %0d", SweepACQData,
                                 cycleCount);
                        errCount++;
                    end else begin
                        expWord = expQ.pop_front();
                        checkValue("SweepACQData", 32'(SweepACQData), 32'(expWord));
                    end
                end
                if (LoadSCParameter) begin
                    if (expDacQ.size() == 0) begin
                        $display("Unexpected LoadSCParameter at cycle %0d", cycleCount);
                        errCount++;
                    end else begin
                        expDac = expDacQ.pop_front();
                        checkValue("OutDAC0", 32'(OutDAC0), 32'(expDac));
                    end
                end
                if (ACQDone) begin
                    acqDoneTotal++;
                end
            end
        end
    end

    // One sweep: expected stream, start edge, wait for ACQDone
    task automatic runSweep(input int r);
        int steps;
        int kept;
        int dac;
        int lat;
        int doneBefore;
        int errBefore;
        logic [15:0] word;
        errBefore  = errCount;
        doneBefore = acqDoneTotal;
        steps = (sweepRows[r].startDac > sweepRows[r].endDac) ? 1
              : sweepRows[r].endDac - sweepRows[r].startDac + 1;
        kept = (sweepRows[r].offered < sweepRows[r].maxWords) ? sweepRows[r].offered
             : sweepRows[r].maxWords;
        for (int s = 0; s < steps; s++) begin
            dac = sweepRows[r].startDac + s;
            expDacQ.push_back(dac);
            expQ.push_back({HdrTag, 10'(dac)});
            for (int i = 0; i < sweepRows[r].offered; i++) begin
                word = 16'($urandom);
                offeredQ.push_back(word);
                if (i < kept) begin
                    expQ.push_back(word);
                end
            end
        end
        @(posedge Clk);
        #2;
        StartDAC0        = 10'(sweepRows[r].startDac);
        EndDAC0          = 10'(sweepRows[r].endDac);
        MaxPackageNumber = 16'(sweepRows[r].maxWords);
        offeredPerStep   = sweepRows[r].offered;
        earlyStopOn      = sweepRows[r].earlyStop;
        pressureOn       = sweepRows[r].backPressure;
        repeat (2) @(posedge Clk);
        #2 SweepStart = 1'b1;
        // Three edges from the drive to the LoadDac state
        lat = 0;
        do begin
            @(posedge Clk);
            lat++;
            @(negedge Clk);
        end while (!LoadSCParameter && lat < 8);
        checkValue("LoadSCParameter latency", 32'(lat), 32'd3);
        // Second start edge in mid sweep
        if (steps > 1) begin
            repeat (2) @(posedge Clk);
            #2 SweepStart = 1'b0;
            repeat (3) @(posedge Clk);
            #2 SweepStart = 1'b1;
        end
        while (acqDoneTotal == doneBefore) begin
            @(negedge Clk);
        end
        // Room for a stray second ACQDone or extra load
        repeat (30) @(negedge Clk);
        @(posedge Clk);
        #2 SweepStart = 1'b0;
        pressureOn = 0;
        checkValue("ACQDone count", 32'(acqDoneTotal - doneBefore), 32'd1);
        if (expQ.size() != 0 || expDacQ.size() != 0) begin
            $display("Sweep %0d ended with %0d words and %0d DAC loads missing", r,
                     expQ.size(), expDacQ.size());
            errCount++;
            expQ.delete();
            expDacQ.delete();
        end
        if (errCount != errBefore) begin
            failedSweeps++;
        end
        $display("Sweep %0d: DAC %0d..%0d max %0d offered %0d early %0d full %0d -> %s",
                 r, sweepRows[r].startDac, sweepRows[r].endDac, sweepRows[r].maxWords,
                 sweepRows[r].offered, sweepRows[r].earlyStop, sweepRows[r].backPressure,
                 (errCount == errBefore) ? "ok" : "MISMATCH");
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        void'($urandom(32'hfbb0));
        reset_n          = 1'b0;
        SweepStart       = 1'b0;
        StartDAC0        = 10'd0;
        EndDAC0          = 10'd0;
        MaxPackageNumber = 16'd0;
        // start, end, max, offered per step, early stop, USB full
        sweepRows[0] = '{5, 8, 8, 8, 0, 0};
        sweepRows[1] = '{100, 102, 4, 10, 0, 0};
        sweepRows[2] = '{20, 22, 16, 5, 1, 0};
        sweepRows[3] = '{7, 7, 10, 0, 1, 0};
        sweepRows[4] = '{300, 304, 12, 12, 0, 1};
        sweepRows[5] = '{1020, 1023, 128, 130, 0, 1};
        // Start above end runs StartDAC0 only
        sweepRows[6] = '{50, 48, 3, 3, 0, 0};
        cycleLimit = cycleBudget();
        repeat (3) @(posedge Clk);
        #2 reset_n = 1'b1;
        @(negedge Clk);
        checkValue("LoadSCParameter", 32'(LoadSCParameter), 32'd0);
        checkValue("SingleACQStart", 32'(SingleACQStart), 32'd0);
        checkValue("ForceMicrorocAcqReset", 32'(ForceMicrorocAcqReset), 32'd0);
        checkValue("ACQDone", 32'(ACQDone), 32'd0);
        checkValue("SweepACQData_en", 32'(SweepACQData_en), 32'd0);
        checkValue("OutDAC0", 32'(OutDAC0), 32'd0);
        checkValue("SweepACQData", 32'(SweepACQData), 32'd0);
        for (int r = 0; r < RowCount; r++) begin
            runSweep(r);
        end
        $display("Sweeps run %0d, sweeps with errors %0d, total errors %0d",
                 RowCount, failedSweeps, errCount);
        if (errCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
